//--- design/ldm_pkg.sv
package ldm_pkg;

	// Data and address widths seen by the datapath
	typedef logic [31:0] word;
	typedef logic [29:0] ptr;
	typedef logic [3:0]  reg_num;
	typedef logic [15:0] reg_list;

	// Block transfer addressing modes
	typedef enum logic [1:0] {
		IA,
		IB,
		DA,
		DB
	} ldm_mode;

	typedef enum logic [2:0] {
		IDLE,
		ISSUE,
		TRANSFER,
		DRAIN,
		BASE_WRITEBACK
	} ldm_cycle;

	// One decoded load/store multiple command
	typedef struct packed {
		reg_num  base;
		reg_list regs;
		logic    load;
		ldm_mode mode;
		logic    writeback;
	} ldm_cmd;

	// Word sized memory request, data is ignored on loads
	typedef struct packed {
		ptr   addr;
		logic write;
		word  data;
	} mem_req;

	typedef struct packed {
		word data;
	} mem_rsp;

endpackage

//--- design/ldm_reg_pop.sv
`timescale 1ns/1ps

module ldm_reg_pop (
	input  logic             clk,
	input  logic             rst,
	input  logic             load,
	input  ldm_pkg::reg_list regs,
	input  logic             next,
	output logic             valid,
	output ldm_pkg::reg_num  popped
);

	ldm_pkg::reg_list remaining;

	assign valid = |remaining;

	// Scan from the top so the lowest set bit wins
	always_comb begin
		popped = '0;
		for (int i = 15; i >= 0; i--) begin
			if (remaining[i])
				popped = ldm_pkg::reg_num'(i);
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			remaining <= '0;
		else if (load)
			remaining <= regs;
		else if (next)
			remaining <= remaining & (remaining - 16'd1);
	end

endmodule

//--- design/ldm_addr_gen.sv
`timescale 1ns/1ps

module ldm_addr_gen (
	input  logic             clk,
	input  logic             rst,
	input  logic             load,
	input  ldm_pkg::word     base_value,
	input  ldm_pkg::reg_list regs,
	input  ldm_pkg::ldm_mode mode,
	input  logic             step,
	output ldm_pkg::ptr      addr,
	output ldm_pkg::ptr      final_base
);

	ldm_pkg::ptr base, n, start, last_base;

	assign base = base_value[31:2];
	assign n = ldm_pkg::ptr'($countones(regs));

	// The lowest register always takes the lowest address, so every mode ascends
	always_comb begin
		unique case (mode)
			ldm_pkg::IA: begin
				start = base;
				last_base = base + n;
			end
			ldm_pkg::IB: begin
				start = base + 30'd1;
				last_base = base + n;
			end
			ldm_pkg::DA: begin
				start = base - n + 30'd1;
				last_base = base - n;
			end
			default: begin
				start = base - n;
				last_base = base - n;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			addr <= '0;
			final_base <= '0;
		end else if (load) begin
			addr <= start;
			final_base <= last_base;
		end else if (step) begin
			addr <= addr + 30'd1;
		end
	end

endmodule

//--- design/ldm_reg_file.sv
`timescale 1ns/1ps

module ldm_reg_file (
	input  logic            clk,
	input  logic            rst,
	input  ldm_pkg::reg_num ra,
	input  ldm_pkg::reg_num rb,
	output ldm_pkg::word    a,
	output ldm_pkg::word    b,
	input  logic            we,
	input  ldm_pkg::reg_num wr,
	input  ldm_pkg::word    wd
);

	ldm_pkg::word regs [16];

	// Reads see the old value in the cycle of a write
	assign a = regs[ra];
	assign b = regs[rb];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[wr] <= wd;
		end
	end

endmodule

//--- design/ldm_rsp_queue.sv
`timescale 1ns/1ps

module ldm_rsp_queue #(
	parameter int MEM_CREDITS = 4
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            push,
	input  ldm_pkg::reg_num push_reg,
	input  logic            pop,
	output ldm_pkg::reg_num head,
	output logic            empty
);

	localparam int AW = (MEM_CREDITS > 1) ? $clog2(MEM_CREDITS) : 1;
	localparam int CW = $clog2(MEM_CREDITS + 1);

	ldm_pkg::reg_num slots [MEM_CREDITS];
	logic [AW-1:0] wr_ptr, rd_ptr;
	logic [CW-1:0] count;

	assign head = slots[rd_ptr];
	assign empty = count == '0;

	// Credits keep the number of loads in flight within the depth
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == AW'(MEM_CREDITS - 1)) ? '0 : wr_ptr + AW'(1);
			if (pop)
				rd_ptr <= (rd_ptr == AW'(MEM_CREDITS - 1)) ? '0 : rd_ptr + AW'(1);
			count <= count + CW'(push) - CW'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			slots[wr_ptr] <= push_reg;
	end

endmodule

//--- design/ldm_control.sv
`timescale 1ns/1ps

module ldm_control #(
	parameter int MEM_CREDITS = 4
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            cmd_valid,
	input  ldm_pkg::ldm_cmd cmd,
	output logic            cmd_credit,
	input  logic            mem_credit,
	input  logic            rsp_valid,
	output logic            mem_req_valid,
	input  logic            pop_valid,
	input  ldm_pkg::reg_num popped,
	output logic            pop_load,
	output logic            pop_next,
	output logic            gen_load,
	output logic            gen_step,
	input  ldm_pkg::ptr     final_base,
	output logic            rq_push,
	output logic            rq_pop,
	input  logic            rq_empty,
	input  ldm_pkg::reg_num rq_reg,
	output logic            wr_en,
	output ldm_pkg::reg_num wr_reg,
	output ldm_pkg::word    wr_data,
	output ldm_pkg::reg_num rd_reg_a,
	output ldm_pkg::reg_num rd_reg_b,
	input  ldm_pkg::word    rd_value_a,
	input  ldm_pkg::word    rsp_data
);

	localparam int CW = $clog2(MEM_CREDITS + 1);

	ldm_pkg::ldm_cycle state, next_state;
	ldm_pkg::ldm_cmd cmd_q;
	logic [CW-1:0] credits;
	logic [4:0] left;
	logic issue, do_wb;

	// A request goes out only with a register to send and a credit in hand
	assign issue = state == ldm_pkg::TRANSFER && pop_valid && credits != '0;

	// A loaded base keeps the loaded word instead of the updated base
	assign do_wb = cmd_q.writeback && !(cmd_q.load && cmd_q.regs[cmd_q.base]);

	assign mem_req_valid = issue;
	assign pop_load = state == ldm_pkg::ISSUE;
	assign gen_load = state == ldm_pkg::ISSUE;
	assign pop_next = issue;
	assign gen_step = issue;
	assign rq_push = issue && cmd_q.load;
	assign rq_pop = rsp_valid;
	assign rd_reg_a = cmd_q.base;
	assign rd_reg_b = popped;

	always_comb begin
		next_state = state;
		unique case (state)
			ldm_pkg::IDLE:
				if (cmd_valid)
					next_state = ldm_pkg::ISSUE;
			ldm_pkg::ISSUE:
				next_state = ldm_pkg::TRANSFER;
			ldm_pkg::TRANSFER:
				if (issue && left == 5'd1)
					next_state = ldm_pkg::DRAIN;
			ldm_pkg::DRAIN:
				if (rq_empty)
					next_state = do_wb ? ldm_pkg::BASE_WRITEBACK : ldm_pkg::IDLE;
			ldm_pkg::BASE_WRITEBACK:
				next_state = ldm_pkg::IDLE;
			default:
				next_state = ldm_pkg::IDLE;
		endcase
	end

	// Responses own the write port, the base update only comes once they are all in
	always_comb begin
		wr_en = 1'b0;
		wr_reg = rq_reg;
		wr_data = rsp_data;
		if (rsp_valid) begin
			wr_en = 1'b1;
		end else if (state == ldm_pkg::BASE_WRITEBACK) begin
			wr_en = 1'b1;
			wr_reg = cmd_q.base;
			wr_data = {final_base, 2'b00};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ldm_pkg::IDLE;
			credits <= CW'(MEM_CREDITS);
			left <= '0;
			cmd_credit <= 1'b0;
		end else begin
			state <= next_state;
			credits <= credits + CW'(mem_credit) - CW'(issue);
			if (state == ldm_pkg::ISSUE)
				left <= 5'($countones(cmd_q.regs));
			else if (issue)
				left <= left - 5'd1;
			cmd_credit <= (state == ldm_pkg::DRAIN && rq_empty && !do_wb)
				|| state == ldm_pkg::BASE_WRITEBACK;
		end
	end

	always_ff @(posedge clk) begin
		if (state == ldm_pkg::IDLE && cmd_valid)
			cmd_q <= cmd;
	end

endmodule

//--- design/ldm_cmd_hold.sv
`timescale 1ns/1ps

module ldm_cmd_hold (
	input  logic             clk,
	input  logic             load,
	input  ldm_pkg::ldm_cmd  cmd,
	output ldm_pkg::reg_list regs,
	output ldm_pkg::ldm_mode mode
);

	// Keeps the register list and mode of the accepted command for the datapath
	always_ff @(posedge clk) begin
		if (load) begin
			regs <= cmd.regs;
			mode <= cmd.mode;
		end
	end

endmodule

//--- design/ldm_unit.sv
`timescale 1ns/1ps

module ldm_unit #(
	parameter int MEM_CREDITS = 4
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            cmd_valid,
	input  ldm_pkg::ldm_cmd cmd,
	output logic            cmd_credit,
	output logic            mem_req_valid,
	output ldm_pkg::mem_req req,
	input  logic            mem_credit,
	input  logic            rsp_valid,
	input  ldm_pkg::mem_rsp rsp
);

	logic pop_valid, pop_load, pop_next, gen_load, gen_step;
	logic rq_push, rq_pop, rq_empty, wr_en;
	ldm_pkg::reg_num popped, rq_reg, wr_reg, rd_reg_a, rd_reg_b;
	ldm_pkg::word wr_data, rd_value_a, rd_value_b;
	ldm_pkg::ptr addr, final_base;
	ldm_pkg::reg_list latched_regs;
	ldm_pkg::ldm_mode latched_mode;

	// Only loads enter the response queue, so the push marks a read
	assign req = '{addr: addr, write: !rq_push, data: rd_value_b};

	ldm_control #(
		.MEM_CREDITS(MEM_CREDITS)
	) control (
		.rsp_data(rsp.data),
		.*
	);

	ldm_cmd_hold cmd_hold (
		.clk,
		.load(cmd_valid),
		.cmd,
		.regs(latched_regs),
		.mode(latched_mode)
	);

	ldm_reg_pop reg_pop (
		.clk,
		.rst,
		.load(pop_load),
		.regs(latched_regs),
		.next(pop_next),
		.valid(pop_valid),
		.popped
	);

	ldm_addr_gen addr_gen (
		.clk,
		.rst,
		.load(gen_load),
		.base_value(rd_value_a),
		.regs(latched_regs),
		.mode(latched_mode),
		.step(gen_step),
		.addr,
		.final_base
	);

	ldm_reg_file reg_file (
		.clk,
		.rst,
		.ra(rd_reg_a),
		.rb(rd_reg_b),
		.a(rd_value_a),
		.b(rd_value_b),
		.we(wr_en),
		.wr(wr_reg),
		.wd(wr_data)
	);

	ldm_rsp_queue #(
		.MEM_CREDITS(MEM_CREDITS)
	) rsp_queue (
		.clk,
		.rst,
		.push(rq_push),
		.push_reg(popped),
		.pop(rq_pop),
		.head(rq_reg),
		.empty(rq_empty)
	);

endmodule

//--- dv/ldm_checker.sv
`timescale 1ns/1ps

module ldm_checker #(
	parameter int MEM_CREDITS = 4
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            cmd_valid,
	input  ldm_pkg::ldm_cmd cmd,
	input  ldm_pkg::ptr     exp_first,
	input  ldm_pkg::ptr     exp_final,
	input  logic            cmd_credit,
	input  logic            mem_req_valid,
	input  ldm_pkg::mem_req req,
	input  logic            mem_credit,
	input  logic            rsp_valid,
	input  ldm_pkg::mem_rsp rsp,
	output int              errors
);

	ldm_pkg::word model_regs [16];
	ldm_pkg::word model_mem [ldm_pkg::ptr];
	ldm_pkg::ldm_cmd cur;
	ldm_pkg::ptr first_q, final_q, want_addr;
	ldm_pkg::reg_num to_send [$];
	ldm_pkg::reg_num load_regs [$];
	ldm_pkg::ptr load_addrs [$];
	int sent, in_flight;
	logic active;

	function automatic ldm_pkg::word mem_word(input ldm_pkg::ptr a);
		if (model_mem.exists(a))
			return model_mem[a];
		return {2'b00, a} ^ 32'h5A5A0000;
	endfunction

	task automatic mismatch(input string what, input ldm_pkg::word got, input ldm_pkg::word want);
		$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
		errors++;
	endtask

	task automatic problem(input string what);
		$display("Checker at %0t: %s", $time, what);
		errors++;
	endtask

	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++)
				model_regs[i] = '0;
			errors = 0;
			active = 1'b0;
			in_flight = 0;
			load_regs.delete();
			load_addrs.delete();
		end else begin
			if (cmd_valid) begin
				cur = cmd;
				first_q = exp_first;
				final_q = exp_final;
				sent = 0;
				active = 1'b1;
				to_send.delete();
				for (int i = 0; i < 16; i++)
					if (cmd.regs[i])
						to_send.push_back(ldm_pkg::reg_num'(i));
			end
			if (rsp_valid) begin
				if (load_regs.size() == 0) begin
					problem("load response arrived with no load in flight");
				end else begin
					if (rsp.data !== mem_word(load_addrs[0]))
						mismatch("load data", rsp.data, mem_word(load_addrs[0]));
					model_regs[load_regs[0]] = rsp.data;
					void'(load_regs.pop_front());
					void'(load_addrs.pop_front());
				end
			end
			if (mem_req_valid) begin
				if (!active || to_send.size() == 0) begin
					problem("memory request outside of any listed register");
				end else begin
					// Lowest register first, one word higher for each one after it
					want_addr = first_q + ldm_pkg::ptr'(sent);
					if (req.addr !== want_addr)
						mismatch("request address", {2'b00, req.addr}, {2'b00, want_addr});
					if (req.write === cur.load)
						problem("request direction does not match the command");
					if (cur.load) begin
						load_regs.push_back(to_send[0]);
						load_addrs.push_back(req.addr);
					end else begin
						if (req.data !== model_regs[to_send[0]])
							mismatch("store data", req.data, model_regs[to_send[0]]);
						model_mem[req.addr] = req.data;
					end
					void'(to_send.pop_front());
					sent++;
				end
			end
			in_flight = in_flight + int'(mem_req_valid) - int'(mem_credit);
			if (in_flight > MEM_CREDITS)
				problem($sformatf("%0d memory requests outstanding", in_flight));
			if (cmd_credit) begin
				if (!active)
					problem("cmd_credit returned with no command in progress");
				else if (to_send.size() != 0 || load_regs.size() != 0)
					problem("command retired with transfers still pending");
				if (active && cur.writeback && !(cur.load && cur.regs[cur.base]))
					model_regs[cur.base] = {final_q, 2'b00};
				active = 1'b0;
			end
		end
	end

endmodule

//--- dv/ldm_properties.sv
`timescale 1ns/1ps

module ldm_properties #(
	parameter int MEM_CREDITS = 4
) (
	input logic                               clk,
	input logic                               rst,
	input logic [$clog2(MEM_CREDITS + 1)-1:0] credits,
	input logic                               mem_req_valid,
	input logic                               mem_credit,
	input logic                               cmd_credit
);

	int outstanding;

	// Requests still waiting for their credit to come back from the memory
	always @(posedge clk) begin
		if (rst)
			outstanding <= 0;
		else
			outstanding <= outstanding + int'(mem_req_valid) - int'(mem_credit);
	end

	credits_bounded: assert property (@(posedge clk) disable iff (rst)
		int'(credits) <= MEM_CREDITS)
		else $error("memory credit count above %0d", MEM_CREDITS);

	no_request_without_credit: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid |-> outstanding < MEM_CREDITS)
		else $error("memory request issued with no credit left");

	// One retire per command, so the credit is never returned twice in a row
	single_cmd_credit: assert property (@(posedge clk) disable iff (rst)
		cmd_credit |=> !cmd_credit)
		else $error("cmd_credit high in two consecutive cycles");

endmodule

bind ldm_control ldm_properties #(
	.MEM_CREDITS(MEM_CREDITS)
) properties_i (
	.clk,
	.rst,
	.credits,
	.mem_req_valid,
	.mem_credit,
	.cmd_credit
);

//--- dv/ldm_tb.sv
`timescale 1ns/1ps

module ldm_tb;

	localparam int MEM_CREDITS = 4;
	localparam int MAX_CMDS = 32;
	localparam int TIMEOUT = 300;

	logic clk = 1'b0;
	logic rst;
	logic cmd_valid;
	ldm_pkg::ldm_cmd cmd;
	logic cmd_credit;
	logic mem_req_valid;
	ldm_pkg::mem_req req;
	logic mem_credit = 1'b0;
	logic rsp_valid = 1'b0;
	ldm_pkg::mem_rsp rsp = '0;
	ldm_pkg::ptr exp_first;
	ldm_pkg::ptr exp_final;
	int errors;

	logic [31:0] vectors [7 * MAX_CMDS];
	ldm_pkg::word mem [ldm_pkg::ptr];
	logic pend_load [$];
	ldm_pkg::word pend_data [$];
	int pend_wait [$];
	logic [31:0] seed = 32'd29191;
	int passed;
	int failed;
	logic timed_out;

	always #5 clk = ~clk;

	ldm_unit #(.MEM_CREDITS(MEM_CREDITS)) ldm_unit_i (.*);

	ldm_checker #(.MEM_CREDITS(MEM_CREDITS)) ldm_checker_i (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic ldm_pkg::word memory_word(input ldm_pkg::ptr a);
		if (mem.exists(a))
			return mem[a];
		return {2'b00, a} ^ 32'h5A5A0000;
	endfunction

	// The memory answers in order and each request waits 0 to 3 cycles behind the one before it
	always @(posedge clk) begin
		if (rst) begin
			pend_load.delete();
			pend_data.delete();
			pend_wait.delete();
		end else if (mem_req_valid) begin
			seed = lcg_next(seed);
			pend_load.push_back(!req.write);
			pend_wait.push_back(int'(seed[17:16]));
			if (req.write)
				mem[req.addr] = req.data;
			pend_data.push_back(memory_word(req.addr));
		end
		#1;
		mem_credit = 1'b0;
		rsp_valid = 1'b0;
		if (pend_wait.size() != 0 && pend_wait[0] == 0) begin
			mem_credit = 1'b1;
			rsp_valid = pend_load[0];
			rsp.data = pend_data[0];
			void'(pend_load.pop_front());
			void'(pend_data.pop_front());
			void'(pend_wait.pop_front());
		end
		foreach (pend_wait[i])
			if (pend_wait[i] > 0)
				pend_wait[i] = pend_wait[i] - 1;
	end

	task automatic run_command(input int n);
		ldm_pkg::ldm_cmd c;
		int cycles;
		int errors_before;
		logic retired;
		c.base = vectors[7 * n][3:0];
		c.regs = vectors[7 * n + 1][15:0];
		c.load = vectors[7 * n + 2][0];
		c.mode = ldm_pkg::ldm_mode'(vectors[7 * n + 3][1:0]);
		c.writeback = vectors[7 * n + 4][0];
		errors_before = errors;
		exp_first = vectors[7 * n + 5][29:0];
		exp_final = vectors[7 * n + 6][29:0];
		cmd = c;
		cmd_valid = 1'b1;
		@(posedge clk);
		#1 cmd_valid = 1'b0;
		cycles = 0;
		retired = 1'b0;
		while (!retired && cycles < TIMEOUT) begin
			@(posedge clk);
			retired = cmd_credit;
			cycles++;
		end
		#1;
		if (!retired) begin
			$display("Command %0d never returned its credit within %0d cycles", n, TIMEOUT);
			timed_out = 1'b1;
			failed++;
		end else begin
			$display("cmd %0d %s %s base r%0d list %04h wb %0d: %s", n,
				c.load ? "load " : "store", c.mode.name(), c.base, c.regs, c.writeback,
				(errors == errors_before) ? "ok" : "FAILED");
			if (errors == errors_before)
				passed++;
			else
				failed++;
		end
	endtask

	// Store credits may still be coming back after the last command retired
	task automatic wait_memory_idle();
		int cycles;
		cycles = 0;
		while (pend_wait.size() != 0 && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (pend_wait.size() != 0) begin
			$display("Memory still had %0d requests waiting at the end", pend_wait.size());
			timed_out = 1'b1;
		end
		@(posedge clk);
		#1;
	endtask

	initial begin
		int n;
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		exp_first = '0;
		exp_final = '0;
		passed = 0;
		failed = 0;
		timed_out = 1'b0;
		foreach (vectors[i])
			vectors[i] = '1;
		$readmemh("dv/ldm_vectors.txt", vectors);
		repeat (5) @(posedge clk);
		#1 rst = 1'b0;
		n = 0;
		while (n < MAX_CMDS && vectors[7 * n] != '1 && !timed_out) begin
			run_command(n);
			n++;
		end
		if (!timed_out)
			wait_memory_idle();
		$display("%0d commands passed, %0d failed, %0d checker errors", passed, failed, errors);
		if (failed == 0 && errors == 0 && !timed_out)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- dv/ldm_vectors.txt
// base list load mode writeback first_word_addr final_base, all hex, one command per line
// mode 0 IA, 1 IB, 2 DA, 3 DB
0 001E 1 0 1 00000000 00000004
0 001E 0 1 1 00000005 00000008
0 01E0 1 2 1 00000005 00000004
0 0060 0 3 0 00000002 00000002
0 0200 1 0 0 00000004 00000005
0 0401 1 0 1 00000004 00000006
0 0C00 0 0 0 16968001 16968003
C E0FE 1 1 1 00000001 0000000A
C FFFF 0 3 1 3FFFFFFA 3FFFFFFA
C 000F 1 0 1 3FFFFFFA 3FFFFFFE
C 1111 1 2 1 3FFFFFFB 3FFFFFFA
C 8001 0 1 0 16968002 16968003
C 0002 0 2 1 16968001 16968000
C 7FFE 1 3 1 16967FF2 16967FF2

//--- list.f
design/ldm_pkg.sv
design/ldm_reg_pop.sv
design/ldm_addr_gen.sv
design/ldm_reg_file.sv
design/ldm_rsp_queue.sv
design/ldm_control.sv
design/ldm_cmd_hold.sv
design/ldm_unit.sv
dv/ldm_checker.sv
dv/ldm_properties.sv
dv/ldm_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = ldm_tb
FILELIST = list.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
